//--- vlog.f
verilog/tcp_tx_pkg.sv
verilog/tcp_segmenter.sv
verilog/tcp_data_buffer.sv
verilog/tcp_seg_table.sv
verilog/tcp_retrans_sched.sv
verilog/tcp_tx_reader.sv
verilog/tcp_tx_queue.sv
sim/tcp_tx_queue_assert.sv
sim/tcp_tx_queue_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tcp_tx_queue_tb
FILELIST  := vlog.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tcp_tx_queue_tb.sv
module tcp_tx_queue_tb
	import tcp_tx_pkg::*;
();

	localparam int MTU               = 16;
	localparam int DEPTH             = 8;
	localparam int SEG_DEPTH         = 2;
	localparam int WAIT_TICKS        = 8;
	localparam int RETRANSMIT_PASSES = 4;
	localparam int TIMEOUT           = 4000;  // cycles allowed for any single wait

	typedef logic [7:0] byte_q_t [$];

	logic       clk;
	logic       rst;
	logic [7:0] in_d;
	logic       in_v;
	seq_t       isn;
	seq_t       rem_ack;
	logic       connected;
	logic       flush_queue;
	logic       cts;
	logic [7:0] tx_d;
	logic       tx_v;
	logic       tx_start;
	seq_t       tx_seq;
	len_t       tx_len;
	csum_t      tx_checksum;
	logic       tx_done;
	logic       force_fin;
	logic       queue_flushed;

	logic [7:0] model [1024];  // user bytes by offset from isn
	int         n_sent;
	int         ack_off;       // offsets below this are acked
	string      test_name;

	// finished transmissions, monitor to test process
	seq_t       got_seq [$];
	len_t       got_len [$];
	logic       got_fin [$];

	// transmission being captured
	len_t       cap_len;
	csum_t      cap_csum;
	logic       cap_fin;
	int         cap_off;
	byte_q_t    cap_bytes;

	tcp_tx_queue #(
		.MTU               (MTU),
		.DEPTH             (DEPTH),
		.SEG_DEPTH         (SEG_DEPTH),
		.WAIT_TICKS        (WAIT_TICKS),
		.RETRANSMIT_PASSES (RETRANSMIT_PASSES)
	) UUT (.*);

	bind tcp_tx_queue tcp_tx_queue_assert assert_inst (
		.clk           (clk),
		.rst           (rst),
		.tx_start      (tx_start),
		.tx_v          (tx_v),
		.tx_done       (tx_done),
		.tx_len        (tx_len),
		.queue_flushed (queue_flushed)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] got);
		abort_run($sformatf("Error: %s %s expected %0h actual %0h", test_name, what, exp, got));
	endtask

	// big-endian 16-bit words, odd tail padded low, no folding
	function automatic csum_t ref_csum(input byte_q_t q);
		csum_t s;
		int    i;
		s = '0;
		for (i = 0; i < q.size(); i += 2) begin
			if (i + 1 < q.size()) s += {16'h0, q[i], q[i+1]};
			else s += {16'h0, q[i], 8'h00};
		end
		return s;
	endfunction

	// comparison process, samples on the falling edge
	always @(negedge clk) begin
		byte_q_t ref_q;
		int      i;
		if (!rst) begin
			if (tx_start) begin
				cap_len  = tx_len;
				cap_csum = tx_checksum;
				cap_fin  = force_fin;
				cap_off  = int'(tx_seq - isn);
				cap_bytes.delete();
				assert (cap_off >= ack_off && cap_off + int'(tx_len) <= n_sent) else
					abort_run($sformatf("%s: tx_seq offset %0d is not unacked sent data",
						test_name, cap_off));
				assert (tx_len <= MTU) else value_error("tx_len bound", MTU, tx_len);
			end
			if (tx_v) cap_bytes.push_back(tx_d);
			if (tx_done) begin
				ref_q.delete();
				for (i = 0; i < int'(cap_len); i++) ref_q.push_back(model[cap_off + i]);
				assert (cap_bytes.size() == int'(cap_len)) else
					value_error("byte count", cap_len, cap_bytes.size());
				assert (cap_csum == ref_csum(ref_q)) else
					value_error("tx_checksum", ref_csum(ref_q), cap_csum);
				for (i = 0; i < int'(cap_len); i++) begin
					assert (cap_bytes[i] == ref_q[i]) else
						value_error($sformatf("byte %0d", i), ref_q[i], cap_bytes[i]);
				end
				got_seq.push_back(isn + seq_t'(cap_off));
				got_len.push_back(cap_len);
				got_fin.push_back(cap_fin);
			end
		end
	end

	task automatic send_bytes(input int n);
		int         i;
		int         t;
		logic [7:0] b;
		for (i = 0; i < n; i++) begin
			t = 0;
			@(negedge clk);
			while (!cts) begin
				@(posedge clk);
				in_v <= 1'b0;  // hold while the queue is full
				t++;
				if (t > TIMEOUT) abort_run($sformatf("%s: cts never came back", test_name));
				@(negedge clk);
			end
			b = 8'($urandom());
			@(posedge clk);
			in_d <= b;
			in_v <= 1'b1;
			model[n_sent] = b;
			n_sent++;
		end
		@(posedge clk);
		in_v <= 1'b0;
	endtask

	task automatic wait_cts();
		int t;
		t = 0;
		@(negedge clk);
		while (!cts) begin
			t++;
			if (t > TIMEOUT) abort_run($sformatf("%s: timeout waiting for cts", test_name));
			@(negedge clk);
		end
	endtask

	// skips other segments, those are already checked
	task automatic wait_send(input seq_t seq, output len_t len, output logic fin);
		int   t;
		logic found;
		t     = 0;
		found = 1'b0;
		while (!found) begin
			@(negedge clk);
			while (got_seq.size() > 0 && !found) begin
				if (got_seq[0] == seq) begin
					len   = got_len[0];
					fin   = got_fin[0];
					found = 1'b1;
				end
				void'(got_seq.pop_front());
				void'(got_len.pop_front());
				void'(got_fin.pop_front());
			end
			t++;
			if (!found && t > TIMEOUT)
				abort_run($sformatf("%s: segment %0h was never sent", test_name, seq));
		end
	endtask

	task automatic wait_flushed();
		int t;
		t = 0;
		@(negedge clk);
		while (!queue_flushed) begin
			t++;
			if (t > TIMEOUT) abort_run("flush: queue_flushed never pulsed");
			@(negedge clk);
		end
	endtask

	task automatic expect_quiet(input int cycles);
		int i;
		for (i = 0; i < cycles; i++) begin
			@(negedge clk);
			assert (!tx_start) else
				abort_run($sformatf("%s: tx_start where nothing is due", test_name));
		end
	endtask

	task automatic ack_to(input int off);
		@(posedge clk);
		rem_ack <= isn + seq_t'(off);
		repeat (2) @(posedge clk);  // decisions already past the read stage
		ack_off = off;
	endtask

	initial begin
		len_t len;
		logic fin;
		int   r;
		int   base;
		int   k;
		void'($urandom(32'hdd8bef6a));
		isn         = $urandom();
		rem_ack     = isn;  // nothing acked yet
		in_d        = 8'h00;
		in_v        = 1'b0;
		connected   = 1'b0;
		flush_queue = 1'b0;
		rst         = 1'b1;
		n_sent      = 0;
		ack_off     = 0;
		test_name   = "reset";
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		connected <= 1'b1;
		wait_cts();

		test_name = "idle_cut";
		r = 1 + int'($urandom() % 15);
		send_bytes(r);
		wait_send(isn, len, fin);
		assert (len == r) else value_error("tx_len", r, len);
		ack_to(n_sent);
		expect_quiet(100);

		test_name = "mtu_split";
		base = n_sent;
		send_bytes(2 * MTU + 5);
		for (k = 0; k < 3; k++) begin
			wait_send(isn + seq_t'(base + k * MTU), len, fin);
			assert (len == ((k < 2) ? MTU : 5)) else value_error("tx_len", (k < 2) ? MTU : 5, len);
		end

		test_name = "ack_free";
		ack_to(n_sent);
		expect_quiet(200);  // acked segments stay silent
		wait_cts();

		test_name = "resend";
		base = n_sent;
		send_bytes(7);
		for (k = 1; k <= 4; k++) begin
			wait_send(isn + seq_t'(base), len, fin);
			assert (len == 7) else value_error("tx_len", 7, len);
			// send k starts with k-1 tries done
			assert (fin == (k - 1 >= int'(MAX_TRIES))) else
				value_error($sformatf("force_fin at send %0d", k), k - 1 >= int'(MAX_TRIES), fin);
		end
		ack_to(n_sent);
		expect_quiet(200);

		test_name = "table_full";
		base = n_sent;
		for (k = 0; k < 2 ** SEG_DEPTH; k++) begin
			send_bytes(2);
			wait_send(isn + seq_t'(base + 2 * k), len, fin);
		end
		assert (!cts) else value_error("cts", 0, cts);
		ack_to(base + 2);  // frees the oldest entry only
		wait_cts();

		test_name = "flush";
		assert (force_fin) else value_error("force_fin", 1, force_fin);
		@(posedge clk);
		flush_queue <= 1'b1;
		wait_flushed();
		@(posedge clk);
		flush_queue <= 1'b0;
		expect_quiet(200);
		assert (!force_fin) else value_error("force_fin", 0, force_fin);
		base = n_sent;
		send_bytes(5);
		wait_send(isn + seq_t'(base), len, fin);
		assert (len == 5) else value_error("tx_len", 5, len);

		$display("sim passed");
		$finish;
	end

endmodule : tcp_tx_queue_tb

//--- sim/tcp_tx_queue_assert.sv
module tcp_tx_queue_assert
	import tcp_tx_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic tx_start,
	input logic tx_v,
	input logic tx_done,
	input len_t tx_len,
	input logic queue_flushed
);

	logic in_tx;  // between tx_start and tx_done

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_tx <= 1'b0;
		end else if (tx_start) begin
			in_tx <= 1'b1;
		end else if (tx_done) begin
			in_tx <= 1'b0;
		end
	end

	// bytes only inside a transmission
	tx_v_framed: assert property (@(posedge clk) disable iff (rst) tx_v |-> in_tx)
		else $error("tx_v high outside a transmission");

	flushed_pulse: assert property (@(posedge clk) disable iff (rst)
		queue_flushed |=> !queue_flushed)
		else $error("queue_flushed longer than one cycle");

	done_pulse: assert property (@(posedge clk) disable iff (rst) tx_done |=> !tx_done)
		else $error("tx_done longer than one cycle");

	// empty segments are never scheduled
	len_nonzero: assert property (@(posedge clk) disable iff (rst) tx_start |-> tx_len != '0)
		else $error("tx_start with zero tx_len");

endmodule : tcp_tx_queue_assert

//--- verilog/tcp_tx_queue.sv
module tcp_tx_queue
	import tcp_tx_pkg::*;
#(
	parameter int MTU               = 1400,
	parameter int DEPTH             = 10,
	parameter int SEG_DEPTH         = 3,
	parameter int WAIT_TICKS        = 20,
	parameter int RETRANSMIT_PASSES = 1000
) (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] in_d,
	input  logic       in_v,
	input  seq_t       isn,
	input  seq_t       rem_ack,
	input  logic       connected,
	input  logic       flush_queue,
	output logic       cts,
	output logic [7:0] tx_d,
	output logic       tx_v,
	output logic       tx_start,
	output seq_t       tx_seq,
	output len_t       tx_len,
	output csum_t      tx_checksum,
	output logic       tx_done,
	output logic       force_fin,
	output logic       queue_flushed
);

	localparam int PW = $clog2(RETRANSMIT_PASSES + 1);

	// segmenter side
	logic                 buf_rst;
	logic [DEPTH-1:0]     space_left;
	logic                 seg_load;
	logic [SEG_DEPTH-1:0] seg_addr;
	seq_t                 seg_seq;
	seq_t                 seg_exp_ack;
	len_t                 seg_len;
	csum_t                seg_csum;
	logic                 seg_free;
	logic                 flush_done;

	// table update port
	logic                 upd;
	logic [SEG_DEPTH-1:0] upd_addr;
	logic                 upd_present;
	logic [PW-1:0]        upd_passes;
	tries_t               upd_tries;
	logic                 cur_present;
	seq_t                 cur_seq;
	seq_t                 cur_exp_ack;
	len_t                 cur_len;
	csum_t                cur_csum;
	logic [PW-1:0]        cur_passes;
	tries_t               cur_tries;

	// payload read
	logic [DEPTH-1:0]     rd_addr;
	logic [7:0]           rd_q;

	tcp_segmenter #(
		.MTU        (MTU),
		.DEPTH      (DEPTH),
		.SEG_DEPTH  (SEG_DEPTH),
		.WAIT_TICKS (WAIT_TICKS)
	) segmenter_inst (.*);

	tcp_data_buffer #(
		.DEPTH (DEPTH)
	) data_buffer_inst (
		.wr_d (in_d),
		.wr_v (in_v),
		.*
	);

	tcp_seg_table #(
		.SEG_DEPTH         (SEG_DEPTH),
		.RETRANSMIT_PASSES (RETRANSMIT_PASSES)
	) seg_table_inst (.*);

	// a load in flight holds off the scan
	tcp_retrans_sched #(
		.SEG_DEPTH         (SEG_DEPTH),
		.RETRANSMIT_PASSES (RETRANSMIT_PASSES)
	) sched_inst (
		.seg_closing (seg_load),
		.*
	);

	tcp_tx_reader #(
		.DEPTH (DEPTH)
	) reader_inst (.*);

endmodule : tcp_tx_queue

//--- verilog/tcp_tx_reader.sv
module tcp_tx_reader
	import tcp_tx_pkg::*;
#(
	parameter int DEPTH = 10
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             tx_start,
	input  seq_t             tx_seq,
	input  len_t             tx_len,
	input  logic [7:0]       rd_q,
	output logic [DEPTH-1:0] rd_addr,
	output logic [7:0]       tx_d,
	output logic             tx_v,
	output logic             tx_done
);

	logic active;   // an address is being issued this cycle
	len_t left;     // addresses still to issue

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active  <= 1'b0;
			left    <= '0;
			rd_addr <= '0;
			tx_v    <= 1'b0;
			tx_done <= 1'b0;
		end else begin
			tx_v    <= active;            // ram answers one cycle later
			tx_done <= tx_v && !active;   // after the last byte
			if (tx_start) begin
				active  <= tx_len != '0;
				left    <= tx_len;
				rd_addr <= tx_seq[DEPTH-1:0]; // buffer is indexed by seq
			end else if (active) begin
				rd_addr <= rd_addr + 1'b1;
				left    <= left - 1'b1;
				if (left == 16'd1) active <= 1'b0;
			end
		end
	end

	assign tx_d = rd_q;

endmodule : tcp_tx_reader

//--- verilog/tcp_retrans_sched.sv
module tcp_retrans_sched
	import tcp_tx_pkg::*;
#(
	parameter int SEG_DEPTH         = 3,
	parameter int RETRANSMIT_PASSES = 1000,
	localparam int PW = $clog2(RETRANSMIT_PASSES + 1)
) (
	input  logic                 clk,
	input  logic                 rst,
	input  seq_t                 rem_ack,
	input  logic                 flush_queue,
	input  logic                 buf_rst,
	input  logic                 seg_closing,
	input  logic                 cur_present,
	input  seq_t                 cur_seq,
	input  seq_t                 cur_exp_ack,
	input  len_t                 cur_len,
	input  csum_t                cur_csum,
	input  logic [PW-1:0]        cur_passes,
	input  tries_t               cur_tries,
	input  logic                 tx_done,
	output logic                 upd,
	output logic [SEG_DEPTH-1:0] upd_addr,
	output logic                 upd_present,
	output logic [PW-1:0]        upd_passes,
	output tries_t               upd_tries,
	output logic                 seg_free,
	output logic                 flush_done,
	output logic                 queue_flushed,
	output logic                 force_fin,
	output logic                 tx_start,
	output seq_t                 tx_seq,
	output len_t                 tx_len,
	output csum_t                tx_checksum
);

	localparam logic [PW-1:0]      PASS_MAX = PW'(RETRANSMIT_PASSES);
	localparam logic [SEG_DEPTH:0] SEGS     = (SEG_DEPTH + 1)'(2**SEG_DEPTH);

	typedef enum logic [2:0] {
		scan_s,
		read_s,
		check_s,
		next_s,
		send_s,
		flush_s
	} state_t;

	state_t             state;
	seq_t               ack_diff;
	logic               acked;
	logic               do_free;
	logic               do_send;
	logic               do_age;
	logic               clr_pend;   // reconnect seen, table must be wiped
	logic               flush_ext;  // wipe came from flush_queue
	logic [SEG_DEPTH:0] flush_ctr;

	// serial-number compare, wraps cleanly
	assign ack_diff = rem_ack - cur_exp_ack;
	assign acked    = !ack_diff[31];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state         <= scan_s;
			upd           <= 1'b0;
			upd_addr      <= '0;
			upd_present   <= 1'b0;
			upd_passes    <= '0;
			upd_tries     <= '0;
			seg_free      <= 1'b0;
			flush_done    <= 1'b0;
			queue_flushed <= 1'b0;
			force_fin     <= 1'b0;
			tx_start      <= 1'b0;
			do_free       <= 1'b0;
			do_send       <= 1'b0;
			do_age        <= 1'b0;
			clr_pend      <= 1'b1;
			flush_ext     <= 1'b0;
			flush_ctr     <= '0;
		end else begin
			seg_free      <= 1'b0; // pulses
			flush_done    <= 1'b0;
			queue_flushed <= 1'b0;
			tx_start      <= 1'b0;
			case (state)
				scan_s: begin
					upd <= 1'b0;
					if (flush_queue || clr_pend) begin
						state     <= flush_s;
						flush_ext <= flush_queue;
						clr_pend  <= 1'b0;
						flush_ctr <= '0;
					end else if (!seg_closing) begin // table port busy with a load
						state <= read_s;
					end
				end
				read_s: begin // cur_ now holds entry upd_addr
					do_free <= cur_present && acked;
					do_send <= cur_present && !acked && (cur_passes == PASS_MAX);
					do_age  <= cur_present && !acked && (cur_passes != PASS_MAX);
					state   <= check_s;
				end
				check_s: begin
					upd         <= do_free || do_send || do_age;
					upd_present <= !do_free;
					upd_passes  <= cur_passes + 1'b1;  // aging
					upd_tries   <= cur_tries;
					state       <= next_s;
					if (do_free) begin
						upd_passes <= '0;
						upd_tries  <= '0;
						seg_free   <= 1'b1;
					end else if (do_send) begin
						upd_passes <= '0;
						if (cur_tries == MAX_TRIES) force_fin <= 1'b1; // give up
						else upd_tries <= cur_tries + 1'b1;
						tx_start <= 1'b1;
						state    <= send_s;
					end
				end
				next_s: begin
					upd      <= 1'b0;
					upd_addr <= upd_addr + 1'b1;
					state    <= scan_s;
				end
				send_s: begin
					upd <= 1'b0;
					if (tx_done) state <= next_s; // reader finished the segment
				end
				flush_s: begin
					// one entry cleared per cycle
					upd         <= 1'b1;
					upd_addr    <= flush_ctr[SEG_DEPTH-1:0];
					upd_present <= 1'b0;
					upd_passes  <= '0;
					upd_tries   <= '0;
					flush_ctr   <= flush_ctr + 1'b1;
					if (flush_ctr == SEGS) begin // last write lands this edge
						upd           <= 1'b0;
						upd_addr      <= '0;
						flush_done    <= 1'b1;
						queue_flushed <= flush_ext;
						force_fin     <= 1'b0;
						state         <= scan_s;
					end
				end
				default: state <= scan_s;
			endcase
			if (buf_rst) begin
				clr_pend  <= 1'b1;
				force_fin <= 1'b0;
			end
		end
	end

	// held for the reader until tx_done
	always_ff @(posedge clk) begin
		if (state == check_s && do_send) begin
			tx_seq      <= cur_seq;
			tx_len      <= cur_len;
			tx_checksum <= cur_csum;
		end
	end

endmodule : tcp_retrans_sched

//--- verilog/tcp_seg_table.sv
module tcp_seg_table
	import tcp_tx_pkg::*;
#(
	parameter int SEG_DEPTH         = 3,
	parameter int RETRANSMIT_PASSES = 1000,
	localparam int PW = $clog2(RETRANSMIT_PASSES + 1)
) (
	input  logic                 clk,
	input  logic                 seg_load,
	input  logic [SEG_DEPTH-1:0] seg_addr,
	input  seq_t                 seg_seq,
	input  seq_t                 seg_exp_ack,
	input  len_t                 seg_len,
	input  csum_t                seg_csum,
	input  logic                 upd,
	input  logic [SEG_DEPTH-1:0] upd_addr,
	input  logic                 upd_present,
	input  logic [PW-1:0]        upd_passes,
	input  tries_t               upd_tries,
	output logic                 cur_present,
	output seq_t                 cur_seq,
	output seq_t                 cur_exp_ack,
	output len_t                 cur_len,
	output csum_t                cur_csum,
	output logic [PW-1:0]        cur_passes,
	output tries_t               cur_tries
);

	localparam int SEGS = 2**SEG_DEPTH;

	// fixed part of a descriptor, written only on load
	seq_t  seq_mem  [SEGS];
	seq_t  ack_mem  [SEGS];
	len_t  len_mem  [SEGS];
	csum_t csum_mem [SEGS];

	// status part, rewritten by the scheduler
	logic          pres_mem  [SEGS];
	logic [PW-1:0] pass_mem  [SEGS];
	tries_t        tries_mem [SEGS];

	always_ff @(posedge clk) begin
		if (seg_load) begin
			seq_mem[seg_addr]  <= seg_seq;
			ack_mem[seg_addr]  <= seg_exp_ack;
			len_mem[seg_addr]  <= seg_len;
			csum_mem[seg_addr] <= seg_csum;
		end
	end

	always_ff @(posedge clk) begin
		if (upd) begin
			pres_mem[upd_addr]  <= upd_present;
			pass_mem[upd_addr]  <= upd_passes;
			tries_mem[upd_addr] <= upd_tries;
		end
		if (seg_load) begin // load wins on a shared address
			pres_mem[seg_addr]  <= 1'b1;
			pass_mem[seg_addr]  <= PW'(RETRANSMIT_PASSES); // due at first visit
			tries_mem[seg_addr] <= '0;
		end
	end

	// update port read, write-through on its own write
	always_ff @(posedge clk) begin
		cur_seq     <= seq_mem[upd_addr];
		cur_exp_ack <= ack_mem[upd_addr];
		cur_len     <= len_mem[upd_addr];
		cur_csum    <= csum_mem[upd_addr];
		if (upd) begin
			cur_present <= upd_present;
			cur_passes  <= upd_passes;
			cur_tries   <= upd_tries;
		end else begin
			cur_present <= pres_mem[upd_addr];
			cur_passes  <= pass_mem[upd_addr];
			cur_tries   <= tries_mem[upd_addr];
		end
	end

endmodule : tcp_seg_table

//--- verilog/tcp_data_buffer.sv
module tcp_data_buffer
	import tcp_tx_pkg::*;
#(
	parameter int DEPTH = 10
) (
	input  logic             clk,
	input  logic             buf_rst,
	input  logic [7:0]       wr_d,
	input  logic             wr_v,
	input  seq_t             isn,
	input  seq_t             rem_ack,
	input  logic [DEPTH-1:0] rd_addr,
	output logic [7:0]       rd_q,
	output logic [DEPTH-1:0] space_left
);

	logic [7:0]   mem [2**DEPTH];
	logic [DEPTH:0] wr_ptr;   // next byte to store, with wrap bit
	logic [DEPTH:0] fr_ptr;   // oldest unacked byte
	logic [DEPTH:0] diff;
	logic           full;
	logic           wr_ok;

	assign diff  = wr_ptr - fr_ptr;
	assign full  = diff[DEPTH];
	assign wr_ok = wr_v && !full;  // bytes past a full buffer are dropped

	// one slot short of the ram size
	assign space_left = full ? '0 : ~diff[DEPTH-1:0];

	always_ff @(posedge clk) begin
		if (buf_rst) begin
			wr_ptr <= isn[DEPTH:0];
			fr_ptr <= isn[DEPTH:0];
		end else begin
			if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
			fr_ptr <= rem_ack[DEPTH:0]; // acked bytes become free
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok) mem[wr_ptr[DEPTH-1:0]] <= wr_d;
		rd_q <= mem[rd_addr];
	end

endmodule : tcp_data_buffer

//--- verilog/tcp_segmenter.sv
module tcp_segmenter
	import tcp_tx_pkg::*;
#(
	parameter int MTU        = 1400,
	parameter int DEPTH      = 10,
	parameter int SEG_DEPTH  = 3,
	parameter int WAIT_TICKS = 20
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [7:0]           in_d,
	input  logic                 in_v,
	input  seq_t                 isn,
	input  logic                 connected,
	input  logic [DEPTH-1:0]     space_left,
	input  logic                 seg_free,
	input  logic                 flush_done,
	output logic                 cts,
	output logic                 buf_rst,
	output logic                 seg_load,
	output logic [SEG_DEPTH-1:0] seg_addr,
	output seq_t                 seg_seq,
	output seq_t                 seg_exp_ack,
	output len_t                 seg_len,
	output csum_t                seg_csum
);

	localparam int IW = $clog2(WAIT_TICKS + 1);
	localparam logic [IW-1:0]        IDLE_MAX = IW'(WAIT_TICKS);
	localparam len_t                 MTU_LEN  = len_t'(MTU);
	localparam logic [DEPTH-1:0]     MTU_SPC  = DEPTH'(MTU);
	localparam logic [SEG_DEPTH+1:0] SEGS     = (SEG_DEPTH + 2)'(2**SEG_DEPTH);

	logic                 conn_q;
	seq_t                 cur_seq;  // seq of the next byte to arrive
	len_t                 ctr;      // bytes in the open segment
	logic [IW-1:0]        idle;     // saturating idle tick count
	csum_t                sum;
	logic [7:0]           hi_byte;  // upper byte of a half word
	logic                 odd;
	logic                 close;
	logic                 pend;
	logic [SEG_DEPTH:0]   occ;      // loaded and not yet freed
	logic [SEG_DEPTH+1:0] need;

	// full segment, or partial one gone quiet
	assign close = (ctr == MTU_LEN) || (idle == IDLE_MAX && ctr != '0);
	assign pend  = (ctr != '0) || seg_load; // one more entry on its way
	assign need  = {1'b0, occ} + {{(SEG_DEPTH + 1){1'b0}}, pend};

	// any edge on connected restarts buffer and sequence
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			conn_q  <= 1'b0;
			buf_rst <= 1'b1;
		end else begin
			conn_q  <= connected;
			buf_rst <= conn_q != connected;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cur_seq  <= '0;
			ctr      <= '0;
			idle     <= '0;
			sum      <= '0;
			odd      <= 1'b0;
			seg_load <= 1'b0;
		end else if (buf_rst) begin
			cur_seq  <= isn;
			ctr      <= '0;
			idle     <= '0;
			sum      <= '0;
			odd      <= 1'b0;
			seg_load <= 1'b0;
		end else begin
			seg_load <= close; // descriptor is latched this cycle
			if (in_v) begin
				cur_seq <= cur_seq + 1'b1;
				idle    <= '0;
			end else if (idle != IDLE_MAX) begin
				idle <= idle + 1'b1;
			end
			if (close) begin
				// a byte on the closing cycle opens the next segment
				ctr <= {15'd0, in_v};
				sum <= '0;
				odd <= in_v;
			end else if (in_v) begin
				ctr <= ctr + 1'b1;
				odd <= ~odd;
				if (odd) sum <= sum + {16'h0, hi_byte, in_d}; // big-endian word
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_v && (close || !odd)) hi_byte <= in_d;
	end

	// descriptor of the segment being cut
	always_ff @(posedge clk) begin
		if (close) begin
			seg_seq     <= cur_seq - {16'h0, ctr};
			seg_exp_ack <= cur_seq;
			seg_len     <= ctr;
			seg_csum    <= odd ? sum + {16'h0, hi_byte, 8'h00} : sum; // pad odd tail
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			seg_addr <= '0;
			occ      <= '0;
			cts      <= 1'b0;
		end else begin
			if (buf_rst) seg_addr <= '0;
			else if (seg_load) seg_addr <= seg_addr + 1'b1;
			if (buf_rst || flush_done) occ <= '0; // table emptied
			else if (seg_load && !seg_free) occ <= occ + 1'b1;
			else if (seg_free && !seg_load) occ <= occ - 1'b1;
			// open segment counts as taken
			cts <= connected && !buf_rst && (need < SEGS) && (space_left >= MTU_SPC);
		end
	end

endmodule : tcp_segmenter

//--- verilog/tcp_tx_pkg.sv
package tcp_tx_pkg;

	// 32-bit tcp sequence or ack number
	typedef logic [31:0] seq_t;

	typedef logic [15:0] len_t;   // segment length in bytes

	// payload sum of big-endian 16-bit words, carries kept above bit 15
	typedef logic [31:0] csum_t;

	typedef logic [1:0] tries_t;  // sends done for one segment

	// a send with tries already here gives up on the connection
	localparam tries_t MAX_TRIES = 2'd3;

endpackage : tcp_tx_pkg
